// File: frontEndPkg.sv
// Branch-prediction front end shared definitions
// Widths, vector types, opcodes and predictor constants
`default_nettype none

package frontEndPkg;

    localparam int XlenBits   = 32;
    localparam int BtbEntries = 32;
    localparam int BtbIdxBits = 5;
    localparam int BtbTagBits = XlenBits - BtbIdxBits - 2;
    localparam int GhrBits    = 5;
    localparam int PhtEntries = 1 << GhrBits;

    typedef logic [XlenBits-1:0]   pcT;
    typedef logic [XlenBits-1:0]   instrT;
    typedef logic [6:0]            opcodeT;
    typedef logic [BtbIdxBits-1:0] btbIdxT;
    typedef logic [BtbTagBits-1:0] btbTagT;
    typedef logic [GhrBits-1:0]    ghrT;
    typedef logic [1:0]            counterT;

    // First fetch address after reset
    localparam pcT ResetPc = 32'h0000_1000;

    // Predicted major opcodes
    localparam opcodeT OpBranch = 7'b1100011;
    localparam opcodeT OpJal    = 7'b1101111;

    // Conditional branch kinds resolved in execute
    localparam logic [2:0] Funct3Beq = 3'd0;
    localparam logic [2:0] Funct3Bne = 3'd1;

    // Saturating counter encoding, 0 strongly not taken up to 3 strongly taken
    localparam counterT CounterInit    = 2'd1;
    localparam counterT TakenThreshold = 2'd2;
    localparam counterT CounterMax     = 2'd3;

endpackage

`default_nettype wire

// File: fetchPc.sv
// Fetch program counter with next-PC selection
// Forms the fetch-time taken prediction from opcode, BTB and counter table
`timescale 1ns/1ps
`default_nettype none

module fetchPc
    import frontEndPkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   stall_i,
    input  opcodeT opcodeF_i,
    input  logic   btbHit_i,
    input  pcT     btbTarget_i,
    input  logic   predictTaken_i,
    input  logic   mispredict_i,
    input  pcT     redirectPc_i,
    output pcT     pc_o,
    output logic   takenF_o
);

    pcT pcPlus4;
    pcT pcNext;

    // Branches need both a target and a taken counter, jal only a target
    always_comb begin
        case (opcodeF_i)
            OpBranch: takenF_o = btbHit_i && predictTaken_i;
            OpJal:    takenF_o = btbHit_i;
            default:  takenF_o = 1'b0;
        endcase
    end

    assign pcPlus4 = pc_o + 32'd4;

    // Redirect from execute beats the stall
    always_comb begin
        if (mispredict_i) begin
            pcNext = redirectPc_i;
        end else if (stall_i) begin
            pcNext = pc_o;
        end else if (takenF_o) begin
            pcNext = btbTarget_i;
        end else begin
            pcNext = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_o <= ResetPc;
        end else begin
            pc_o <= pcNext;
        end
    end

endmodule

`default_nettype wire

// File: branchTargetBuffer.sv
// Direct-mapped, tagged branch target buffer
// Read combinationally in fetch, written from execute at the end of the cycle
`timescale 1ns/1ps
`default_nettype none

module branchTargetBuffer
    import frontEndPkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  pcT     pcF_i,
    output logic   hit_o,
    output pcT     target_o,
    input  logic   we_i,
    input  btbIdxT wrIdx_i,
    input  btbTagT wrTag_i,
    input  pcT     wrTarget_i
);

    logic [BtbEntries-1:0] validQ;
    btbTagT                tagMem    [BtbEntries];
    pcT                    targetMem [BtbEntries];

    btbIdxT rdIdx;
    btbTagT rdTag;

    // Word-aligned PC, so bits 1:0 are skipped
    assign rdIdx = pcF_i[BtbIdxBits+1:2];
    assign rdTag = pcF_i[XlenBits-1:BtbIdxBits+2];

    assign hit_o    = validQ[rdIdx] && (tagMem[rdIdx] == rdTag);
    assign target_o = targetMem[rdIdx];

    always_ff @(posedge clk) begin
        if (reset) begin
            validQ <= '0;
        end else if (we_i) begin
            validQ[wrIdx_i] <= 1'b1;
        end
    end

    // Tag and target storage
    always_ff @(posedge clk) begin
        if (we_i) begin
            tagMem[wrIdx_i]    <= wrTag_i;
            targetMem[wrIdx_i] <= wrTarget_i;
        end
    end

endmodule

`default_nettype wire

// File: globalHistory.sv
// Global history register and pattern history table of 2-bit counters
// History indexes the table directly and is cleared on a mispredict
`timescale 1ns/1ps
`default_nettype none

module globalHistory
    import frontEndPkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   stall_i,
    input  opcodeT opcodeF_i,
    input  logic   takenF_i,
    output ghrT    ghr_o,
    output logic   predictTaken_o,
    input  logic   clear_i,
    input  logic   phtWe_i,
    input  ghrT    phtIdx_i,
    input  logic   phtTaken_i
);

    counterT phtQ [PhtEntries];
    counterT curCount;
    logic    shiftEn;

    assign predictTaken_o = (phtQ[ghr_o] >= TakenThreshold);

    // Speculative update, only conditional branches enter the history
    assign shiftEn = !stall_i && (opcodeF_i == OpBranch);

    always_ff @(posedge clk) begin
        if (reset || clear_i) begin
            ghr_o <= '0;
        end else if (shiftEn) begin
            ghr_o <= {ghr_o[GhrBits-2:0], takenF_i};
        end
    end

    assign curCount = phtQ[phtIdx_i];

    // Saturating training from execute
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < PhtEntries; i++) begin
                phtQ[i] <= CounterInit;
            end
        end else if (phtWe_i) begin
            if (phtTaken_i && curCount != CounterMax) begin
                phtQ[phtIdx_i] <= curCount + 2'd1;
            end else if (!phtTaken_i && curCount != 2'd0) begin
                phtQ[phtIdx_i] <= curCount - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: predictPipe.sv
// Decode and execute pipeline registers
// Carry instruction, PC, fetch prediction and counter index to execute
`timescale 1ns/1ps
`default_nettype none

module predictPipe
    import frontEndPkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  stall_i,
    input  logic  flush_i,
    input  instrT instrF_i,
    input  pcT    pcF_i,
    input  logic  takenF_i,
    input  ghrT   ghrF_i,
    output instrT instrE_o,
    output pcT    pcE_o,
    output logic  takenE_o,
    output ghrT   ghrE_o
);

    instrT instrD;
    pcT    pcD;
    logic  takenD;
    ghrT   ghrD;

    // Decode stage, holds while stalled
    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            instrD <= '0;
            pcD    <= '0;
            takenD <= 1'b0;
            ghrD   <= '0;
        end else if (!stall_i) begin
            instrD <= instrF_i;
            pcD    <= pcF_i;
            takenD <= takenF_i;
            ghrD   <= ghrF_i;
        end
    end

    // Execute stage, an all-zero instruction is a bubble
    always_ff @(posedge clk) begin
        if (reset || flush_i || stall_i) begin
            instrE_o <= '0;
            pcE_o    <= '0;
            takenE_o <= 1'b0;
            ghrE_o   <= '0;
        end else begin
            instrE_o <= instrD;
            pcE_o    <= pcD;
            takenE_o <= takenD;
            ghrE_o   <= ghrD;
        end
    end

endmodule

`default_nettype wire

// File: branchResolve.sv
// Execute-stage branch resolution for beq, bne and jal
// Finds the real outcome, flags a mispredict and trains both tables
`timescale 1ns/1ps
`default_nettype none

module branchResolve
    import frontEndPkg::*;
(
    input  instrT  instrE_i,
    input  pcT     pcE_i,
    input  logic   takenE_i,
    input  ghrT    ghrE_i,
    input  pcT     rs1Val_i,
    input  pcT     rs2Val_i,
    output logic   mispredict_o,
    output pcT     redirectPc_o,
    output logic   btbWe_o,
    output btbIdxT btbWrIdx_o,
    output btbTagT btbWrTag_o,
    output pcT     btbWrTarget_o,
    output logic   phtWe_o,
    output ghrT    phtIdx_o,
    output logic   phtTaken_o
);

    opcodeT     opcodeE;
    logic [2:0] funct3E;
    logic       isJal;
    logic       isCondBranch;
    logic       operandsEq;
    logic       actualTaken;
    pcT         immB;
    pcT         immJ;
    pcT         targetE;

    assign opcodeE = instrE_i[6:0];
    assign funct3E = instrE_i[14:12];

    assign isJal        = (opcodeE == OpJal);
    assign isCondBranch = (opcodeE == OpBranch) &&
                          (funct3E == Funct3Beq || funct3E == Funct3Bne);

    // B and J immediates, both with an implied zero LSB
    assign immB = {{20{instrE_i[31]}}, instrE_i[7], instrE_i[30:25], instrE_i[11:8], 1'b0};
    assign immJ = {{12{instrE_i[31]}}, instrE_i[19:12], instrE_i[20], instrE_i[30:21], 1'b0};

    assign targetE = pcE_i + (isJal ? immJ : immB);

    assign operandsEq = (rs1Val_i == rs2Val_i);

    always_comb begin
        if (isJal) begin
            actualTaken = 1'b1;
        end else if (isCondBranch) begin
            actualTaken = (funct3E == Funct3Beq) ? operandsEq : !operandsEq;
        end else begin
            actualTaken = 1'b0;
        end
    end

    // Also catches anything predicted taken that turns out not to be a branch
    assign mispredict_o = (takenE_i != actualTaken);
    assign redirectPc_o = actualTaken ? targetE : pcE_i + 32'd4;

    // BTB learns every taken branch or jump
    assign btbWe_o       = actualTaken;
    assign btbWrIdx_o    = pcE_i[BtbIdxBits+1:2];
    assign btbWrTag_o    = pcE_i[XlenBits-1:BtbIdxBits+2];
    assign btbWrTarget_o = targetE;

    // Counter index is the history seen at fetch
    assign phtWe_o    = isCondBranch;
    assign phtIdx_o   = ghrE_i;
    assign phtTaken_o = actualTaken;

endmodule

`default_nettype wire

// File: frontEnd.sv
// Branch-prediction front end top level
// Fetch PC, BTB, global history predictor, pipeline registers and resolve
`timescale 1ns/1ps
`default_nettype none

module frontEnd
    import frontEndPkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  stall_i,
    input  instrT instrF_i,
    input  pcT    rs1ValE_i,
    input  pcT    rs2ValE_i,
    output pcT    pcF_o,
    output logic  mispredict_o
);

    opcodeT opcodeF;
    logic   btbHit;
    pcT     btbTarget;
    ghrT    ghrF;
    logic   predictTakenF;
    logic   takenF;

    instrT  instrE;
    pcT     pcE;
    logic   takenE;
    ghrT    ghrE;

    logic   mispredict;
    pcT     redirectPc;
    logic   btbWe;
    btbIdxT btbWrIdx;
    btbTagT btbWrTag;
    pcT     btbWrTarget;
    logic   phtWe;
    ghrT    phtIdx;
    logic   phtTaken;

    assign opcodeF      = instrF_i[6:0];
    assign mispredict_o = mispredict;

    fetchPc fetchPc_inst (
        .clk(clk), .reset(reset), .stall_i(stall_i), .opcodeF_i(opcodeF),
        .btbHit_i(btbHit), .btbTarget_i(btbTarget), .predictTaken_i(predictTakenF),
        .mispredict_i(mispredict), .redirectPc_i(redirectPc),
        .pc_o(pcF_o), .takenF_o(takenF)
    );

    branchTargetBuffer branchTargetBuffer_inst (
        .clk(clk), .reset(reset), .pcF_i(pcF_o), .hit_o(btbHit), .target_o(btbTarget),
        .we_i(btbWe), .wrIdx_i(btbWrIdx), .wrTag_i(btbWrTag), .wrTarget_i(btbWrTarget)
    );

    // Mispredict also wipes the speculative history
    globalHistory globalHistory_inst (
        .clk(clk), .reset(reset), .stall_i(stall_i), .opcodeF_i(opcodeF),
        .takenF_i(takenF), .ghr_o(ghrF), .predictTaken_o(predictTakenF),
        .clear_i(mispredict), .phtWe_i(phtWe), .phtIdx_i(phtIdx), .phtTaken_i(phtTaken)
    );

    predictPipe predictPipe_inst (
        .clk(clk), .reset(reset), .stall_i(stall_i), .flush_i(mispredict),
        .instrF_i(instrF_i), .pcF_i(pcF_o), .takenF_i(takenF), .ghrF_i(ghrF),
        .instrE_o(instrE), .pcE_o(pcE), .takenE_o(takenE), .ghrE_o(ghrE)
    );

    branchResolve branchResolve_inst (
        .instrE_i(instrE), .pcE_i(pcE), .takenE_i(takenE), .ghrE_i(ghrE),
        .rs1Val_i(rs1ValE_i), .rs2Val_i(rs2ValE_i),
        .mispredict_o(mispredict), .redirectPc_o(redirectPc),
        .btbWe_o(btbWe), .btbWrIdx_o(btbWrIdx), .btbWrTag_o(btbWrTag),
        .btbWrTarget_o(btbWrTarget), .phtWe_o(phtWe), .phtIdx_o(phtIdx),
        .phtTaken_o(phtTaken)
    );

endmodule

`default_nettype wire

// File: tbFrontEnd.sv
// Testbench for the branch-prediction front end
// Table of fetch scenarios applied cycle by cycle against expected PCs and mispredicts
`timescale 1ns/1ps
`default_nettype none

module tbFrontEnd
    import frontEndPkg::*;
();

    localparam int ClkPeriod   = 10;
    localparam int ResetCycles = 8;
    localparam int NumRows     = 7;
    localparam int NumCycles   = 8;
    localparam int MemWords    = 256;

    // Operand relations for the value in execute
    localparam int SameOps = 0;
    localparam int DiffOps = 1;
    localparam int AnyOps  = 2;

    localparam opcodeT OpImm = 7'b0010011;

    logic  clk;
    logic  reset;
    logic  stall;
    instrT instrF;
    pcT    rs1ValE;
    pcT    rs2ValE;
    pcT    pcF;
    logic  mispredict;

    instrT imem [MemWords];
    integer seed;
    int checkCount;
    int errorCount;

    // Scenario table
    string                rowName   [NumRows];
    pcT                   placePc   [NumRows];
    instrT                placeWord [NumRows];
    pcT                   rs1Val    [NumRows];
    pcT                   rs2Val    [NumRows];
    logic [NumCycles-1:0] stallMask [NumRows];
    logic [NumCycles-1:0] expMis    [NumRows];
    pcT                   expPc     [NumRows][NumCycles];

    frontEnd frontEnd_inst (
        .clk(clk), .reset(reset), .stall_i(stall), .instrF_i(instrF),
        .rs1ValE_i(rs1ValE), .rs2ValE_i(rs2ValE),
        .pcF_o(pcF), .mispredict_o(mispredict)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // rs1 = x1, rs2 = x2
    function automatic instrT encodeBranch(input logic [2:0] funct3, input logic [12:0] offset);
        encodeBranch = {offset[12], offset[10:5], 5'd2, 5'd1, funct3, offset[4:1], offset[11],
                        OpBranch};
    endfunction

    function automatic instrT encodeJal(input logic [20:0] offset);
        encodeJal = {offset[20], offset[10:1], offset[11], offset[19:12], 5'd0, OpJal};
    endfunction

    task automatic setRow(input int r, input string name, input pcT pc, input instrT word,
                          input logic [NumCycles-1:0] stalls, input logic [NumCycles-1:0] mis);
        rowName[r]   = name;
        placePc[r]   = pc;
        placeWord[r] = word;
        stallMask[r] = stalls;
        expMis[r]    = mis;
    endtask

    task automatic pickOperands(input int r, input int relation);
        pcT a;
        pcT b;
        a = $random(seed);
        b = $random(seed);
        rs1Val[r] = a;
        if (relation == SameOps) begin
            rs2Val[r] = a;
        end else if (relation == DiffOps) begin
            rs2Val[r] = a ^ 32'h1;
        end else begin
            rs2Val[r] = b;
        end
    endtask

    task automatic buildTable();
        instrT beqWord;
        beqWord = encodeBranch(Funct3Beq, -13'sd32);
        // Straight-line fetch with a two-cycle hold
        setRow(0, "resetAndStall", 32'h1000, 32'h0010_0093, 8'b0001_1000, 8'b0000_0000);
        pickOperands(0, AnyOps);
        expPc[0] = '{32'h1000, 32'h1004, 32'h1008, 32'h100C,
                     32'h100C, 32'h100C, 32'h1010, 32'h1014};
        // beq at 1020 back to 1000, missed while cold
        setRow(1, "coldBeqTaken", 32'h1020, beqWord, 8'b0000_0000, 8'b0001_0000);
        pickOperands(1, SameOps);
        expPc[1] = '{32'h1018, 32'h101C, 32'h1020, 32'h1024,
                     32'h1028, 32'h1000, 32'h1004, 32'h1008};
        setRow(2, "trainedBeqTaken", 32'h1020, beqWord, 8'b0000_0000, 8'b0000_0000);
        pickOperands(2, SameOps);
        expPc[2] = '{32'h100C, 32'h1010, 32'h1014, 32'h1018,
                     32'h101C, 32'h1020, 32'h1000, 32'h1004};
        setRow(3, "bneNotTaken", 32'h1010, encodeBranch(Funct3Bne, 13'sd64),
               8'b0000_0000, 8'b0000_0000);
        pickOperands(3, SameOps);
        expPc[3] = '{32'h1008, 32'h100C, 32'h1010, 32'h1014,
                     32'h1018, 32'h101C, 32'h1020, 32'h1024};
        // jal at 1030 back to 1010
        setRow(4, "coldJal", 32'h1030, encodeJal(-21'sd32), 8'b0000_0000, 8'b0001_0000);
        pickOperands(4, AnyOps);
        expPc[4] = '{32'h1028, 32'h102C, 32'h1030, 32'h1034,
                     32'h1038, 32'h1010, 32'h1014, 32'h1018};
        // Stall in the mispredict cycle loses to the redirect
        setRow(5, "trainedBeqNotTaken", 32'h1020, beqWord, 8'b0110_1000, 8'b0000_1000);
        pickOperands(5, DiffOps);
        expPc[5] = '{32'h101C, 32'h1020, 32'h1000, 32'h1004,
                     32'h1024, 32'h1028, 32'h1028, 32'h1028};
        setRow(6, "trainedJal", 32'h1030, encodeJal(-21'sd32), 8'b0000_0000, 8'b0000_0000);
        pickOperands(6, AnyOps);
        expPc[6] = '{32'h102C, 32'h1030, 32'h1010, 32'h1014,
                     32'h1018, 32'h101C, 32'h1020, 32'h1024};
    endtask

    task automatic checkCycle(input int r, input int c);
        checkCount++;
        if (pcF !== expPc[r][c]) begin
            errorCount++;
            $display("ERROR %s cycle %0d pcF_o expected %h actual %h",
                     rowName[r], c, expPc[r][c], pcF);
        end
        checkCount++;
        if (mispredict !== expMis[r][c]) begin
            errorCount++;
            $display("ERROR %s cycle %0d mispredict_o expected %b actual %b",
                     rowName[r], c, expMis[r][c], mispredict);
        end
    endtask

    // Watchdog
    initial begin
        #((NumRows * 20 + ResetCycles) * ClkPeriod);
        $display("Timeout, the scenario table did not finish in time");
        $display("Checks failed");
        $finish;
    end

    initial begin
        logic [31:0] randWord;
        instrT       savedWord;
        logic [7:0]  memIdx;
        reset      = 1'b1;
        stall      = 1'b0;
        instrF     = '0;
        rs1ValE    = '0;
        rs2ValE    = '0;
        seed       = 32'h7f6b;
        checkCount = 0;
        errorCount = 0;
        // Filler words never carry a branch opcode
        for (int i = 0; i < MemWords; i++) begin
            randWord = $random(seed);
            imem[i]  = {randWord[31:7], OpImm};
        end
        buildTable();
        repeat (ResetCycles) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int r = 0; r < NumRows; r++) begin
            memIdx       = placePc[r][9:2];
            savedWord    = imem[memIdx];
            imem[memIdx] = placeWord[r];
            for (int c = 0; c < NumCycles; c++) begin
                stall   = stallMask[r][c];
                instrF  = imem[pcF[9:2]];
                rs1ValE = rs1Val[r];
                rs2ValE = rs2Val[r];
                #3;
                checkCycle(r, c);
                @(posedge clk);
                #1;
            end
            imem[memIdx] = savedWord;
        end
        $display("Checks run %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
frontEndPkg.sv
fetchPc.sv
branchTargetBuffer.sv
globalHistory.sv
predictPipe.sv
branchResolve.sv
frontEnd.sv
tbFrontEnd.sv

// File: run.sh
#!/bin/sh
# Build and run the front-end testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tbFrontEnd -f src.f -o simFrontEnd
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simFrontEnd > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "All checks passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
